//--- am_lock_pkg.sv
/*
  Alignment marker lock package: coded block and marker field types,
  configuration bundle, register map, lock FSM states and lane marker table
*/
`default_nettype none

package am_lock_pkg;

    localparam int NB_BLOCK     = 66;
    localparam int NB_AM        = 48;
    localparam int NB_BIP       = 8;
    localparam int NB_AM_PERIOD = 14;
    localparam int NB_THR       = 3;

    // coded block seen as a marker, M0 first on the wire
    typedef struct packed {
        logic [1:0]        sync;   // sync header
        logic [23:0]       m012;   // M0 M1 M2
        logic [NB_BIP-1:0] bip3;
        logic [23:0]       m456;   // M4 M5 M6
        logic [NB_BIP-1:0] bip7;
    } am_block_t;

    typedef struct packed {
        logic                    enable;
        logic [NB_THR-1:0]       valid_thr;
        logic [NB_THR-1:0]       invalid_thr;
        logic [NB_AM-1:0]        compare_mask;   // 1 = bit compared
        logic [NB_AM_PERIOD-1:0] am_period;      // data blocks between markers
        logic [2:0]              spare;
    } am_cfg_t;

    localparam logic [2:0] CFG_CTRL    = 3'd0;
    localparam logic [2:0] CFG_THR     = 3'd1;
    localparam logic [2:0] CFG_MASK_LO = 3'd2;
    localparam logic [2:0] CFG_MASK_HI = 3'd3;
    localparam logic [2:0] CFG_PERIOD  = 3'd4;

    typedef enum logic [1:0] {
        ST_RESET  = 2'd0,
        ST_SEARCH = 2'd1,
        ST_VERIFY = 2'd2,
        ST_LOCKED = 2'd3
    } lock_state_t;

    // per-lane marker, M0..M2 then M4..M6 (M4..M6 are the inverted M0..M2)
    localparam logic [NB_AM-1:0] AM_TABLE [20] = '{
        48'hC16821_3E97DE, 48'h9D718E_628E71, 48'h594BE8_A6B417, 48'h4D957B_B26A84,
        48'hF50709_0AF8F6, 48'hDD14C2_22EB3D, 48'h9A4A26_65B5D9, 48'h7B4566_84BA99,
        48'hA02476_5FDB89, 48'h68C9FB_973604, 48'hFD6C99_029366, 48'hB99155_466EAA,
        48'h5CB9B2_A3464D, 48'h1AF8BD_E50742, 48'h83C7CA_7C3835, 48'h3536CD_CAC932,
        48'hC4314C_3BCEB3, 48'hADD6B7_522948, 48'h5F662A_A099D5, 48'hC0F0E5_3F0F1A
    };

endpackage

`default_nettype wire

//--- am_lock_config.sv
/*
  Configuration registers for the marker lock, loaded by single-cycle
  write strobes and presented to the lock logic as one bundle
*/
`timescale 1ns/10ps
`default_nettype none

module am_lock_config
    import am_lock_pkg::*;
(
    input  wire          i_clock,
    input  wire          i_reset,
    input  wire          i_cfg_write,
    input  wire  [2:0]   i_cfg_addr,
    input  wire  [31:0]  i_cfg_wdata,
    output am_cfg_t      o_cfg
);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_cfg.enable       <= 1'b0;
            o_cfg.valid_thr    <= 3'd3;
            o_cfg.invalid_thr  <= 3'd4;
            o_cfg.compare_mask <= '1;             // compare every bit
            o_cfg.am_period    <= '1;             // 16383 blocks
            o_cfg.spare        <= '0;
        end
        else if (i_cfg_write)
        begin
            case (i_cfg_addr)
                CFG_CTRL:
                    o_cfg.enable <= i_cfg_wdata[0];
                CFG_THR:
                begin
                    o_cfg.valid_thr   <= i_cfg_wdata[2:0];
                    o_cfg.invalid_thr <= i_cfg_wdata[6:4];
                end
                CFG_MASK_LO:
                    o_cfg.compare_mask[31:0] <= i_cfg_wdata;
                CFG_MASK_HI:
                    o_cfg.compare_mask[NB_AM-1:32] <= i_cfg_wdata[NB_AM-33:0];
                CFG_PERIOD:
                    o_cfg.am_period <= i_cfg_wdata[NB_AM_PERIOD-1:0];
                default:
                    o_cfg.spare <= o_cfg.spare;    // unmapped address
            endcase
        end
    end

endmodule

`default_nettype wire

//--- am_comparator.sv
/*
  Marker comparator: masked match of the received marker fields against
  the first N_ALIGNER lane table entries, all in parallel
*/
`timescale 1ns/10ps
`default_nettype none

module am_comparator
    import am_lock_pkg::*;
#(
    parameter int N_ALIGNER = 20
)
(
    input  wire am_block_t              i_data,
    input  wire [NB_AM-1:0]             i_compare_mask,
    input  wire [N_ALIGNER-1:0]         i_lane_select,   // one-hot from FSM
    output logic [N_ALIGNER-1:0]        o_match_vector,
    output logic                        o_match
);

    logic [NB_AM-1:0] candidate;

    assign candidate = {i_data.m012, i_data.m456};   // BIP fields skipped

    always_comb
    begin
        for (int lane = 0; lane < N_ALIGNER; lane++)
        begin
            // masked-off bits never cause a mismatch
            o_match_vector[lane] =
                ((candidate ^ AM_TABLE[lane]) & i_compare_mask) == '0;
        end
    end

    assign o_match = |(o_match_vector & i_lane_select);   // chosen lane only

endmodule

`default_nettype wire

//--- am_lock_fsm.sv
/*
  Marker lock FSM: searches for any lane marker, verifies it at the
  programmed period and holds lock until too many slots mismatch
*/
`timescale 1ns/10ps
`default_nettype none

module am_lock_fsm
    import am_lock_pkg::*;
#(
    parameter int N_ALIGNER = 20
)
(
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_valid,
    input  wire                         i_block_lock,
    input  wire am_cfg_t                i_cfg,
    input  wire [N_ALIGNER-1:0]         i_match_vector,
    input  wire                         i_match,
    output logic [N_ALIGNER-1:0]        o_lane_select,
    output logic [$clog2(N_ALIGNER)-1:0] o_lane_id,
    output logic                        o_am_lock,
    output logic                        o_resync,
    output logic                        o_marker_slot
);

    localparam int NB_LANE_ID = $clog2(N_ALIGNER);

    lock_state_t             state;
    logic [NB_AM_PERIOD-1:0] timer;          // blocks left to next slot
    logic [NB_THR-1:0]       valid_count;
    logic [NB_THR-1:0]       invalid_count;
    logic [N_ALIGNER-1:0]    first_lane;
    logic [NB_LANE_ID-1:0]   lane_code;
    logic                    run;
    logic                    slot;
    logic                    valid_done;
    logic                    invalid_done;

    assign run          = i_cfg.enable & i_block_lock;
    assign slot         = (timer == '0);    // this block is an expected marker
    assign valid_done   = ({1'b0, valid_count} + 1'b1) >= {1'b0, i_cfg.valid_thr};
    assign invalid_done = ({1'b0, invalid_count} + 1'b1) >= {1'b0, i_cfg.invalid_thr};

    // lowest matching lane wins during search
    always_comb
    begin
        first_lane = '0;
        for (int i = N_ALIGNER - 1; i >= 0; i--)
        begin
            if (i_match_vector[i])
            begin
                first_lane    = '0;
                first_lane[i] = 1'b1;
            end
        end
    end

    always_comb
    begin
        lane_code = '0;
        for (int i = 0; i < N_ALIGNER; i++)
        begin
            if (o_lane_select[i])
                lane_code = NB_LANE_ID'(i);
        end
    end

    // marker and loss-of-lock strobes belong to the current block
    always_comb
    begin
        o_marker_slot = 1'b0;
        o_resync      = o_am_lock & ~run;    // lock lost with the lane
        if (run && i_valid)
        begin
            case (state)
                ST_SEARCH:
                    o_marker_slot = |i_match_vector;
                ST_VERIFY:
                    o_marker_slot = slot & i_match;
                ST_LOCKED:
                begin
                    o_marker_slot = slot & i_match;
                    o_resync      = slot & ~i_match & invalid_done;
                end
                default:
                    o_marker_slot = 1'b0;
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state         <= ST_RESET;
            timer         <= '0;
            valid_count   <= '0;
            invalid_count <= '0;
            o_lane_select <= '0;
            o_lane_id     <= '0;
            o_am_lock     <= 1'b0;
        end
        else if (!run)
        begin
            state         <= ST_SEARCH;
            valid_count   <= '0;
            invalid_count <= '0;
            o_am_lock     <= 1'b0;
        end
        else if (i_valid)
        begin
            case (state)
                ST_SEARCH:
                begin
                    if (|i_match_vector)
                    begin
                        o_lane_select <= first_lane;
                        timer         <= i_cfg.am_period;
                        valid_count   <= '0;
                        state         <= ST_VERIFY;
                    end
                end
                ST_VERIFY:
                begin
                    if (!slot)
                        timer <= timer - 1'b1;
                    else if (!i_match)
                        state <= ST_SEARCH;       // wrong or missing marker
                    else
                    begin
                        timer <= i_cfg.am_period;
                        if (valid_done)
                        begin
                            state         <= ST_LOCKED;
                            o_am_lock     <= 1'b1;
                            o_lane_id     <= lane_code;
                            invalid_count <= '0;
                        end
                        else
                            valid_count <= valid_count + 1'b1;
                    end
                end
                ST_LOCKED:
                begin
                    if (!slot)
                        timer <= timer - 1'b1;
                    else if (i_match)
                    begin
                        timer         <= i_cfg.am_period;
                        invalid_count <= '0;
                    end
                    else if (invalid_done)
                    begin
                        state         <= ST_SEARCH;
                        o_am_lock     <= 1'b0;
                        invalid_count <= '0;
                    end
                    else
                    begin
                        timer         <= i_cfg.am_period;   // keep slot spacing
                        invalid_count <= invalid_count + 1'b1;
                    end
                end
                default:
                    state <= ST_SEARCH;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- bip_calculator.sv
/*
  BIP3 calculator: running bit-interleaved parity of the coded blocks
  since the last marker, restarted by a marker or a resync
*/
`timescale 1ns/10ps
`default_nettype none

module bip_calculator
    import am_lock_pkg::*;
(
    input  wire                  i_clock,
    input  wire                  i_reset,
    input  wire                  i_valid,
    input  wire [NB_BLOCK-1:0]   i_data,
    input  wire                  i_restart,
    output logic [NB_BIP-1:0]    o_bip
);

    logic [NB_BIP-1:0] accum;
    logic [NB_BIP-1:0] block_parity;

    // bit j covers payload bits 8k+j, sync bits land on 2 and 5
    always_comb
    begin
        block_parity = '0;
        for (int k = 0; k < (NB_BLOCK - 2) / NB_BIP; k++)
        begin
            block_parity = block_parity ^ i_data[k*NB_BIP +: NB_BIP];
        end
        block_parity[2] = block_parity[2] ^ i_data[NB_BLOCK-2];   // sync bit 64
        block_parity[5] = block_parity[5] ^ i_data[NB_BLOCK-1];   // sync bit 65
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            accum <= '0;
        else if (i_restart)
            accum <= '0;                  // marker itself left out
        else if (i_valid)
            accum <= accum ^ block_parity;
    end

    assign o_bip = accum;                 // blocks strictly before this one

endmodule

`default_nettype wire

//--- am_error_counter.sv
/*
  BIP3 error and resync counters: sums differing BIP bits at each locked
  marker and counts loss-of-lock events, both saturating
*/
`timescale 1ns/10ps
`default_nettype none

module am_error_counter
    import am_lock_pkg::*;
#(
    parameter int NB_ERROR_COUNTER  = 32,
    parameter int NB_RESYNC_COUNTER = 8
)
(
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire                          i_marker_slot,
    input  wire                          i_am_lock,
    input  wire                          i_resync,
    input  wire [NB_BIP-1:0]             i_calc_bip,
    input  wire [NB_BIP-1:0]             i_recv_bip,
    output logic [NB_ERROR_COUNTER-1:0]  o_error_count,
    output logic [NB_RESYNC_COUNTER-1:0] o_resync_count
);

    logic [$clog2(NB_BIP+1)-1:0] bit_errors;
    logic [NB_ERROR_COUNTER:0]   error_sum;   // one extra bit for overflow

    always_comb
    begin
        bit_errors = '0;
        for (int i = 0; i < NB_BIP; i++)
            bit_errors = bit_errors + (i_calc_bip[i] ^ i_recv_bip[i]);
    end

    assign error_sum = {1'b0, o_error_count} + (NB_ERROR_COUNTER + 1)'(bit_errors);

    always_ff @(posedge i_clock)
    begin
        if (i_reset || i_resync)
            o_error_count <= '0;
        else if (i_marker_slot && i_am_lock)
            o_error_count <= error_sum[NB_ERROR_COUNTER] ? '1
                                                         : error_sum[NB_ERROR_COUNTER-1:0];
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_resync_count <= '0;
        else if (i_resync && (o_resync_count != '1))
            o_resync_count <= o_resync_count + 1'b1;   // holds at max
    end

endmodule

`default_nettype wire

//--- am_lock_top.sv
/*
  Alignment marker lock, one receive lane: configuration, comparator,
  lock FSM, BIP check and an output stage that swaps markers for idles
*/
`timescale 1ns/10ps
`default_nettype none

module am_lock_top
    import am_lock_pkg::*;
#(
    parameter int N_ALIGNER         = 20,
    parameter int NB_ERROR_COUNTER  = 32,
    parameter int NB_RESYNC_COUNTER = 8
)
(
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire                          i_valid,
    input  wire                          i_block_lock,
    input  wire [NB_BLOCK-1:0]           i_data,
    input  wire                          i_cfg_write,
    input  wire [2:0]                    i_cfg_addr,
    input  wire [31:0]                   i_cfg_wdata,
    output logic                         o_valid,
    output logic [NB_BLOCK-1:0]          o_data,
    output logic                         o_start_of_lane,
    output logic                         o_am_lock,
    output logic [$clog2(N_ALIGNER)-1:0] o_lane_id,
    output logic                         o_resync,
    output logic [NB_ERROR_COUNTER-1:0]  o_error_count,
    output logic [NB_RESYNC_COUNTER-1:0] o_resync_count
);

    localparam logic [NB_BLOCK-1:0] IDLE_BLOCK = {2'b10, 8'h1E, 56'h0};   // control, idles

    am_cfg_t              cfg;
    am_block_t            in_block;
    logic [N_ALIGNER-1:0] match_vector;
    logic [N_ALIGNER-1:0] lane_select;
    logic                 match;
    logic                 marker_slot;
    logic                 resync;
    logic [NB_BIP-1:0]    calc_bip;

    assign in_block = am_block_t'(i_data);

    am_lock_config u_config (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_cfg_write (i_cfg_write),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg       (cfg)
    );

    am_comparator #(.N_ALIGNER(N_ALIGNER)) u_comparator (
        .i_data         (in_block),
        .i_compare_mask (cfg.compare_mask),
        .i_lane_select  (lane_select),
        .o_match_vector (match_vector),
        .o_match        (match)
    );

    am_lock_fsm #(.N_ALIGNER(N_ALIGNER)) u_lock_fsm (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_block_lock   (i_block_lock),
        .i_cfg          (cfg),
        .i_match_vector (match_vector),
        .i_match        (match),
        .o_lane_select  (lane_select),
        .o_lane_id      (o_lane_id),
        .o_am_lock      (o_am_lock),
        .o_resync       (resync),
        .o_marker_slot  (marker_slot)
    );

    bip_calculator u_bip_calculator (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_data    (i_data),
        .i_restart (marker_slot | resync),
        .o_bip     (calc_bip)
    );

    am_error_counter #(
        .NB_ERROR_COUNTER  (NB_ERROR_COUNTER),
        .NB_RESYNC_COUNTER (NB_RESYNC_COUNTER)
    ) u_error_counter (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_marker_slot  (marker_slot),
        .i_am_lock      (o_am_lock),
        .i_resync       (resync),
        .i_calc_bip     (calc_bip),
        .i_recv_bip     (in_block.bip3),
        .o_error_count  (o_error_count),
        .o_resync_count (o_resync_count)
    );

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid         <= 1'b0;
            o_start_of_lane <= 1'b0;
            o_resync        <= 1'b0;
        end
        else
        begin
            o_valid         <= i_valid;
            o_start_of_lane <= marker_slot;
            o_resync        <= resync;
        end
    end

    always_ff @(posedge i_clock)
    begin
        o_data <= marker_slot ? IDLE_BLOCK : i_data;   // marker leaves as idle
    end

endmodule

`default_nettype wire

//--- tb_am_lock.sv
/*
  Testbench for the alignment marker lock: runs the command list from the
  vectors file, builds marker and data blocks and checks every output
*/
`timescale 1ns/10ps
`default_nettype none

module tb_am_lock
    import am_lock_pkg::*;
();

    localparam logic [NB_BLOCK-1:0] IDLE_BLOCK = {2'b10, 8'h1E, 56'h0};
    localparam logic [NB_AM-1:0]    GARBLE     = 48'h00A500_00A500;   // hits M1 and M5

    logic                clock;
    logic                reset;
    logic                valid;
    logic                block_lock;
    logic [NB_BLOCK-1:0] data;
    logic                cfg_write;
    logic [2:0]          cfg_addr;
    logic [31:0]         cfg_wdata;
    logic                out_valid;
    logic [NB_BLOCK-1:0] out_data;
    logic                start_of_lane;
    logic                am_lock;
    logic [4:0]          lane_id;
    logic                resync;
    logic [31:0]         error_count;
    logic [7:0]          resync_count;

    byte cmd_op [$];   // one entry per command line
    int  cmd_a  [$];
    int  cmd_b  [$];
    int  cmd_c  [$];
    int  cmd_d  [$];

    int                cycle_count = 0;
    int                cycle_limit = 32'h7fff_ffff;
    logic [NB_BIP-1:0] bip_acc;        // parity since the last accepted marker
    logic [NB_AM-1:0]  mask_model;
    logic [13:0]       period_model;
    logic              enable_model;
    int                last_lane;
    int                resync_pulses;  // o_resync strobes seen so far

    am_lock_top #(
        .N_ALIGNER (20)
    ) am_lock_top_inst (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_valid         (valid),
        .i_block_lock    (block_lock),
        .i_data          (data),
        .i_cfg_write     (cfg_write),
        .i_cfg_addr      (cfg_addr),
        .i_cfg_wdata     (cfg_wdata),
        .o_valid         (out_valid),
        .o_data          (out_data),
        .o_start_of_lane (start_of_lane),
        .o_am_lock       (am_lock),
        .o_lane_id       (lane_id),
        .o_resync        (resync),
        .o_error_count   (error_count),
        .o_resync_count  (resync_count)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "watchdog stopped the run");
        end
    end

    // bit j takes payload bits 8k+j, sync bit 64 goes to 2 and 65 to 5
    function automatic logic [NB_BIP-1:0] block_parity(input logic [NB_BLOCK-1:0] blk);
        logic [NB_BIP-1:0] p;
        p = '0;
        for (int i = 0; i < 64; i++)
            p[i % 8] = p[i % 8] ^ blk[i];
        p[2] = p[2] ^ blk[64];
        p[5] = p[5] ^ blk[65];
        return p;
    endfunction

    task automatic check_value(input string name, input logic [NB_BLOCK-1:0] expected,
                               input logic [NB_BLOCK-1:0] actual);
        if (expected !== actual)
        begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    blocks;
        int    period;
        string line;
        byte   op;
        int    a;
        int    b;
        int    c;
        int    d;
        fd = $fopen("tb_am_lock_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tb_am_lock_vectors.txt for reading");
            $display("RESULT: FAIL");
            $fatal(1, "no stimulus file");
        end
        blocks = 0;
        period = 16383;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            op = line.getc(0);
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            case (op)
                "W": void'($sscanf(line, "W %h %h", a, b));
                "M": void'($sscanf(line, "M %d %d %d", a, b, c));
                "G": void'($sscanf(line, "G %d", a));
                "C": void'($sscanf(line, "C %d %d %d %d", a, b, c, d));
                "U": a = 0;
                default: op = 0;          // comment or blank line
            endcase
            if (op != 0)
            begin
                cmd_op.push_back(op);
                cmd_a.push_back(a);
                cmd_b.push_back(b);
                cmd_c.push_back(c);
                cmd_d.push_back(d);
                if (op == "W" && a == CFG_PERIOD)
                    period = b & 32'h3fff;
                else if (op == "M")
                    blocks += b * (period + 1);
                else if (op == "G")
                    blocks += a * (period + 1);
                else if (op == "U")
                    blocks += 1;
            end
        end
        $fclose(fd);
        cycle_limit = blocks * 2 + 100;   // two cycles per block
    endtask

    // one strobe cycle, then one idle cycle
    task automatic send_block(input logic [NB_BLOCK-1:0] blk, input logic lock_in,
                              input logic replaced);
        logic [NB_BLOCK-1:0] expected;
        expected = replaced ? IDLE_BLOCK : blk;
        check_value("o_valid", 1'b0, out_valid);
        check_value("o_resync", 1'b0, resync);   // pulse lasts one cycle
        valid      = 1'b1;
        data       = blk;
        block_lock = lock_in;
        @(negedge clock);
        check_value("o_valid", 1'b1, out_valid);
        check_value("o_data", expected, out_data);
        check_value("o_start_of_lane", replaced, start_of_lane);
        if (resync === 1'b1)
            resync_pulses++;
        valid = 1'b0;
        @(negedge clock);
        block_lock = 1'b1;
    endtask

    task automatic write_cfg(input logic [2:0] addr, input logic [31:0] wdata);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        @(negedge clock);
        cfg_write = 1'b0;
        case (addr)
            CFG_CTRL:    enable_model = wdata[0];
            CFG_MASK_LO: mask_model[31:0] = wdata;
            CFG_MASK_HI: mask_model[47:32] = wdata[15:0];
            CFG_PERIOD:  period_model = wdata[13:0];
            default:     enable_model = enable_model;
        endcase
    endtask

    // marker on last_lane, then period_model random data blocks, count times
    task automatic send_periods(input logic [NB_AM-1:0] am, input int count, input int biterr);
        logic [NB_BIP-1:0]   bip;
        logic [NB_BLOCK-1:0] blk;
        logic                matched;
        for (int n = 0; n < count; n++)
        begin
            bip     = bip_acc ^ NB_BIP'((1 << biterr) - 1);
            blk     = {2'b10, am[47:24], bip, am[23:0], ~bip};
            matched = ((am ^ AM_TABLE[last_lane]) & mask_model) == '0;
            send_block(blk, 1'b1, enable_model & matched);
            if (enable_model && matched)
                bip_acc = '0;
            else
                bip_acc = bip_acc ^ block_parity(blk);
            for (int k = 0; k < period_model; k++)
            begin
                blk = {2'b01, $urandom(), $urandom()};
                send_block(blk, 1'b1, 1'b0);
                bip_acc = bip_acc ^ block_parity(blk);
            end
        end
    endtask

    initial
    begin
        reset         = 1'b1;
        valid         = 1'b0;
        block_lock    = 1'b1;
        data          = '0;
        cfg_write     = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        bip_acc       = '0;
        mask_model    = '1;
        period_model  = '1;
        enable_model  = 1'b0;
        last_lane     = 0;
        resync_pulses = 0;
        void'($urandom(32'h8cbd_06ba));
        load_vectors();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        check_value("o_valid", 1'b0, out_valid);
        check_value("o_am_lock", 1'b0, am_lock);
        check_value("o_start_of_lane", 1'b0, start_of_lane);
        check_value("o_resync", 1'b0, resync);
        check_value("o_error_count", 0, error_count);
        check_value("o_resync_count", 0, resync_count);
        for (int i = 0; i < cmd_op.size(); i++)
        begin
            case (cmd_op[i])
                "W": write_cfg(3'(cmd_a[i]), 32'(cmd_b[i]));
                "M":
                begin
                    last_lane = cmd_a[i];
                    send_periods(AM_TABLE[last_lane], cmd_b[i], cmd_c[i]);
                end
                "G": send_periods(AM_TABLE[last_lane] ^ GARBLE, cmd_a[i], 0);
                "U":
                begin
                    send_block({2'b01, $urandom(), $urandom()}, 1'b0, 1'b0);
                    bip_acc = '0;           // resync restarts the parity
                end
                default:
                begin
                    check_value("o_am_lock", cmd_a[i], am_lock);
                    check_value("o_lane_id", cmd_b[i], lane_id);
                    check_value("o_error_count", cmd_c[i], error_count);
                    check_value("o_resync_count", cmd_d[i], resync_count);
                    check_value("o_resync", cmd_d[i], resync_pulses);
                end
            endcase
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
am_lock_pkg.sv
am_lock_config.sv
am_comparator.sv
am_lock_fsm.sv
bip_calculator.sv
am_error_counter.sv
am_lock_top.sv
tb_am_lock.sv

//--- tb_am_lock_vectors.txt
# W addr data (hex) | M lane count biterr | G count | U | C lock lane errors resyncs
# M, G and C fields are decimal; G reuses the lane of the last M
W 4 10
W 1 43
# enable still off, markers pass untouched and no lock
M 5 3 0
C 0 0 0 0
W 0 1
# search match plus two verified markers, not locked yet
M 5 3 0
C 0 0 0 0
M 5 1 0
C 1 5 0 0
M 5 2 0
C 1 5 0 0
# flipped BIP bits while locked
M 5 1 3
C 1 5 3 0
M 5 2 2
C 1 5 7 0
# three garbled markers then a good one keep lock
G 3
M 5 1 0
C 1 5 7 0
# four garbled markers lose lock
G 4
C 0 5 0 1
# relock on another lane, errors before lock are not counted
M 11 4 1
C 1 11 0 1
M 11 2 1
C 1 11 2 1
U
C 0 11 0 2
# ignore M1 and M5 so garbled markers match
W 3 ff00
W 2 ffff00ff
M 7 1 0
G 3
C 1 7 0 2
G 2
M 7 1 2
C 1 7 2 2
U
C 0 7 0 3
